//--- rtl/huffman_pkg.sv
`default_nettype none

package huffman_pkg;

    localparam int DATA_W  = 8;
    localparam int ADDR_W  = 10;
    localparam int NUM_SYM = 6;
    localparam int SYM_W   = 3;

    // result tables, offsets from the result base
    localparam int COUNT_OFS   = 0;
    localparam int CODE_OFS    = 6;
    localparam int MASK_OFS    = 12;
    localparam int NUM_RESULTS = 18;

    // chain tree: rank r is r ones then a zero, the last rank is all ones
    localparam logic [NUM_SYM-1:0][DATA_W-1:0] RANK_CODE = {
        8'h1f, 8'h1e, 8'h0e, 8'h06, 8'h02, 8'h00
    };

    // lowest length bits set
    localparam logic [NUM_SYM-1:0][DATA_W-1:0] RANK_MASK = {
        8'h1f, 8'h1f, 8'h0f, 8'h07, 8'h03, 8'h01
    };

endpackage

`default_nettype wire

//--- rtl/sram_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port_arbiter (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            fetch_req,
    input  wire  [huffman_pkg::ADDR_W-1:0] fetch_addr,
    output logic                           fetch_gnt,
    input  wire                            write_req,
    input  wire  [huffman_pkg::ADDR_W-1:0] write_addr,
    input  wire  [huffman_pkg::DATA_W-1:0] write_data,
    output logic                           write_gnt,
    output logic [huffman_pkg::ADDR_W-1:0] sram_a,
    output logic [huffman_pkg::DATA_W-1:0] sram_d,
    output logic                           sram_wen
);

    // fetcher always wins
    assign fetch_gnt = fetch_req;
    assign write_gnt = write_req && !fetch_req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sram_a   <= '0;
            sram_wen <= 1'b1;
        end else if (fetch_gnt) begin
            sram_a   <= fetch_addr;
            sram_wen <= 1'b1;
        end else if (write_gnt) begin
            sram_a   <= write_addr;
            sram_wen <= 1'b0;
        end else begin
            // idle: read strobe, address kept
            sram_wen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_gnt) begin
            sram_d <= write_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/symbol_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module symbol_fetch #(
    parameter int SYMBOL_COUNT = 100,
    parameter int INPUT_BASE   = 0
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            fetch_gnt,
    input  wire  [huffman_pkg::DATA_W-1:0] sram_q,
    output logic                           fetch_req,
    output logic [huffman_pkg::ADDR_W-1:0] fetch_addr,
    output logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] counts,
    output logic                           counts_valid
);

    localparam int CNT_W = $clog2(SYMBOL_COUNT + 1);

    logic [CNT_W-1:0] issued;
    logic             last_read;
    // stage 0 address on port, stage 1 data on sram_q, stage 2 counted
    logic [2:0]       vld;
    logic [2:0]       lst;

    assign fetch_req    = (issued != CNT_W'(SYMBOL_COUNT));
    assign last_read    = (issued == CNT_W'(SYMBOL_COUNT - 1));
    assign counts_valid = vld[2] && lst[2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issued     <= '0;
            fetch_addr <= INPUT_BASE[huffman_pkg::ADDR_W-1:0];
            vld        <= '0;
            lst        <= '0;
        end else begin
            vld <= {vld[1:0], fetch_gnt};
            lst <= {lst[1:0], fetch_gnt && last_read};
            if (fetch_gnt) begin
                issued     <= issued + 1'b1;
                fetch_addr <= fetch_addr + 1'b1;
            end
        end
    end

    // only bytes 1 to 6 are symbols
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            counts <= '0;
        end else if (vld[1]) begin
            for (int i = 0; i < huffman_pkg::NUM_SYM; i++) begin
                if (int'(sram_q) == i + 1) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rank_sorter.sv
`timescale 1ns/1ps
`default_nettype none

module rank_sorter (
    input  wire                            clk,
    input  wire                            reset,
    input  wire  [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] counts,
    input  wire                            counts_valid,
    output logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::SYM_W-1:0]  rank_sym,
    output logic                           rank_valid
);

    localparam int GRP = huffman_pkg::NUM_SYM / 2;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_SORT2 = 2'd1;
    localparam logic [1:0] S_SORT3 = 2'd2;
    localparam logic [1:0] S_MERGE = 2'd3;

    logic [1:0] state;
    // entries below GRP hold group a, the rest group b, head first
    logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] cnt_q, src_cnt, nxt_cnt;
    logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::SYM_W-1:0]  sym_q, src_sym, nxt_sym;
    logic [1:0]                      a_left;
    logic [1:0]                      b_left;
    logic [huffman_pkg::SYM_W-1:0]   rank_idx;
    logic                            sort_en;
    logic                            pick_a;
    int                              base;

    // higher count first, lower symbol on a tie
    function automatic logic ranks_before(
        input logic [huffman_pkg::DATA_W-1:0] cnt_a,
        input logic [huffman_pkg::SYM_W-1:0]  sym_a,
        input logic [huffman_pkg::DATA_W-1:0] cnt_b,
        input logic [huffman_pkg::SYM_W-1:0]  sym_b
    );
        return (cnt_a > cnt_b) || ((cnt_a == cnt_b) && (sym_a < sym_b));
    endfunction

    assign sort_en = counts_valid || (state == S_SORT2) || (state == S_SORT3);

    // first compare-exchange happens on the load
    always_comb begin
        src_cnt = cnt_q;
        src_sym = sym_q;
        if (counts_valid) begin
            src_cnt = counts;
            for (int i = 0; i < huffman_pkg::NUM_SYM; i++) begin
                src_sym[i] = i[huffman_pkg::SYM_W-1:0] + 1'b1;
            end
        end
        base    = (state == S_SORT2) ? 1 : 0;
        nxt_cnt = src_cnt;
        nxt_sym = src_sym;
        for (int g = 0; g < huffman_pkg::NUM_SYM; g += GRP) begin
            if (ranks_before(src_cnt[g + base + 1], src_sym[g + base + 1],
                             src_cnt[g + base], src_sym[g + base])) begin
                nxt_cnt[g + base]     = src_cnt[g + base + 1];
                nxt_cnt[g + base + 1] = src_cnt[g + base];
                nxt_sym[g + base]     = src_sym[g + base + 1];
                nxt_sym[g + base + 1] = src_sym[g + base];
            end
        end
    end

    // merge picks between the two group heads
    assign pick_a = (b_left == 2'd0) ||
                    ((a_left != 2'd0) &&
                     ranks_before(cnt_q[0], sym_q[0], cnt_q[GRP], sym_q[GRP]));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            a_left     <= '0;
            b_left     <= '0;
            rank_idx   <= '0;
            rank_valid <= 1'b0;
        end else begin
            rank_valid <= 1'b0;
            if (counts_valid) begin
                state    <= S_SORT2;
                a_left   <= 2'(GRP);
                b_left   <= 2'(GRP);
                rank_idx <= '0;
            end else begin
                case (state)
                    S_SORT2: state <= S_SORT3;
                    S_SORT3: state <= S_MERGE;
                    S_MERGE: begin
                        if (pick_a) begin
                            a_left <= a_left - 1'b1;
                        end else begin
                            b_left <= b_left - 1'b1;
                        end
                        if (int'(rank_idx) == huffman_pkg::NUM_SYM - 1) begin
                            state      <= S_IDLE;
                            rank_valid <= 1'b1;
                        end
                        rank_idx <= rank_idx + 1'b1;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sort_en) begin
            cnt_q <= nxt_cnt;
            sym_q <= nxt_sym;
        end else if (state == S_MERGE) begin
            rank_sym[rank_idx] <= pick_a ? sym_q[0] : sym_q[GRP];
            if (pick_a) begin
                cnt_q[GRP-2:0] <= cnt_q[GRP-1:1];
                sym_q[GRP-2:0] <= sym_q[GRP-1:1];
            end else begin
                cnt_q[huffman_pkg::NUM_SYM-2:GRP] <= cnt_q[huffman_pkg::NUM_SYM-1:GRP+1];
                sym_q[huffman_pkg::NUM_SYM-2:GRP] <= sym_q[huffman_pkg::NUM_SYM-1:GRP+1];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/code_builder.sv
`timescale 1ns/1ps
`default_nettype none

module code_builder (
    input  wire                            clk,
    input  wire                            reset,
    input  wire  [huffman_pkg::NUM_SYM-1:0][huffman_pkg::SYM_W-1:0]  rank_sym,
    input  wire                            rank_valid,
    output logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] sym_code,
    output logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] sym_mask,
    output logic                           codes_valid
);

    logic                          busy;
    logic                          active;
    logic [huffman_pkg::SYM_W-1:0] rank_idx;
    logic [huffman_pkg::SYM_W-1:0] slot;

    // rank 0 is handled in the rank_valid cycle itself
    assign active = rank_valid || busy;
    // table entry of the symbol holding this rank
    assign slot   = rank_sym[rank_idx] - 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            rank_idx    <= '0;
            codes_valid <= 1'b0;
        end else begin
            codes_valid <= 1'b0;
            if (active) begin
                if (int'(rank_idx) == huffman_pkg::NUM_SYM - 1) begin
                    busy        <= 1'b0;
                    rank_idx    <= '0;
                    codes_valid <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    rank_idx <= rank_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            sym_code[slot] <= huffman_pkg::RANK_CODE[rank_idx];
            sym_mask[slot] <= huffman_pkg::RANK_MASK[rank_idx];
        end
    end

endmodule

`default_nettype wire

//--- rtl/result_writer.sv
`timescale 1ns/1ps
`default_nettype none

module result_writer #(
    parameter int RESULT_BASE = 128
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire  [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] counts,
    input  wire  [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] sym_code,
    input  wire  [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] sym_mask,
    input  wire                            codes_valid,
    input  wire                            write_gnt,
    output logic                           write_req,
    output logic [huffman_pkg::ADDR_W-1:0] write_addr,
    output logic [huffman_pkg::DATA_W-1:0] write_data,
    output logic                           finish
);

    localparam int IDX_W = $clog2(huffman_pkg::NUM_RESULTS);

    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] rel;
    logic             busy;
    logic             last_sent;

    assign write_req = busy;

    // index picks table, then symbol within it
    always_comb begin
        if (widx >= IDX_W'(huffman_pkg::MASK_OFS)) begin
            rel        = widx - IDX_W'(huffman_pkg::MASK_OFS);
            write_data = sym_mask[rel[huffman_pkg::SYM_W-1:0]];
        end else if (widx >= IDX_W'(huffman_pkg::CODE_OFS)) begin
            rel        = widx - IDX_W'(huffman_pkg::CODE_OFS);
            write_data = sym_code[rel[huffman_pkg::SYM_W-1:0]];
        end else begin
            rel        = widx - IDX_W'(huffman_pkg::COUNT_OFS);
            write_data = counts[rel[huffman_pkg::SYM_W-1:0]];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            widx      <= '0;
            last_sent <= 1'b0;
            finish    <= 1'b0;
        end else begin
            // last write reaches the port the cycle after its grant
            last_sent <= 1'b0;
            if (last_sent) begin
                finish <= 1'b1;
            end
            if (codes_valid) begin
                busy <= 1'b1;
                widx <= '0;
            end else if (write_gnt) begin
                if (int'(widx) == huffman_pkg::NUM_RESULTS - 1) begin
                    busy      <= 1'b0;
                    last_sent <= 1'b1;
                end
                widx <= widx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (codes_valid) begin
            write_addr <= RESULT_BASE[huffman_pkg::ADDR_W-1:0];
        end else if (write_gnt) begin
            write_addr <= write_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/huffman_top.sv
`timescale 1ns/1ps
`default_nettype none

module huffman_top #(
    parameter int SYMBOL_COUNT = 100,
    parameter int INPUT_BASE   = 0,
    parameter int RESULT_BASE  = 128
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [huffman_pkg::DATA_W-1:0]   sram_q,
    output logic [huffman_pkg::ADDR_W-1:0]   sram_a,
    output logic [huffman_pkg::DATA_W-1:0]   sram_d,
    output logic                             sram_wen,
    output logic                             finish
);

    logic                                                fetch_req;
    logic                                                fetch_gnt;
    logic [huffman_pkg::ADDR_W-1:0]                      fetch_addr;
    logic                                                write_req;
    logic                                                write_gnt;
    logic [huffman_pkg::ADDR_W-1:0]                      write_addr;
    logic [huffman_pkg::DATA_W-1:0]                      write_data;
    logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] counts;
    logic                                                counts_valid;
    logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::SYM_W-1:0]  rank_sym;
    logic                                                rank_valid;
    logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] sym_code;
    logic [huffman_pkg::NUM_SYM-1:0][huffman_pkg::DATA_W-1:0] sym_mask;
    logic                                                codes_valid;

    symbol_fetch #(
        .SYMBOL_COUNT(SYMBOL_COUNT),
        .INPUT_BASE  (INPUT_BASE)
    ) i_symbol_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_gnt   (fetch_gnt),
        .sram_q      (sram_q),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .counts      (counts),
        .counts_valid(counts_valid)
    );

    rank_sorter i_rank_sorter (
        .clk         (clk),
        .reset       (reset),
        .counts      (counts),
        .counts_valid(counts_valid),
        .rank_sym    (rank_sym),
        .rank_valid  (rank_valid)
    );

    code_builder i_code_builder (
        .clk        (clk),
        .reset      (reset),
        .rank_sym   (rank_sym),
        .rank_valid (rank_valid),
        .sym_code   (sym_code),
        .sym_mask   (sym_mask),
        .codes_valid(codes_valid)
    );

    result_writer #(
        .RESULT_BASE(RESULT_BASE)
    ) i_result_writer (
        .clk        (clk),
        .reset      (reset),
        .counts     (counts),
        .sym_code   (sym_code),
        .sym_mask   (sym_mask),
        .codes_valid(codes_valid),
        .write_gnt  (write_gnt),
        .write_req  (write_req),
        .write_addr (write_addr),
        .write_data (write_data),
        .finish     (finish)
    );

    sram_port_arbiter i_sram_port_arbiter (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_addr(fetch_addr),
        .fetch_gnt (fetch_gnt),
        .write_req (write_req),
        .write_addr(write_addr),
        .write_data(write_data),
        .write_gnt (write_gnt),
        .sram_a    (sram_a),
        .sram_d    (sram_d),
        .sram_wen  (sram_wen)
    );

endmodule

`default_nettype wire

//--- tests/huffman_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module huffman_asserts (
    input wire                           clk,
    input wire                           reset,
    input wire                           fetch_req,
    input wire                           fetch_gnt,
    input wire [huffman_pkg::ADDR_W-1:0] fetch_addr,
    input wire                           write_req,
    input wire                           write_gnt,
    input wire [huffman_pkg::ADDR_W-1:0] write_addr,
    input wire [huffman_pkg::ADDR_W-1:0] sram_a,
    input wire                           sram_wen,
    input wire                           finish
);

    // one owner of the port per cycle, seen one clock later on the port
    fetch_on_port: assert property (@(posedge clk) disable iff (reset)
        fetch_gnt |=> sram_wen && (sram_a == $past(fetch_addr)))
        else $error("granted fetch not on the port");

    write_on_port: assert property (@(posedge clk) disable iff (reset)
        write_gnt |=> !sram_wen && (sram_a == $past(write_addr)))
        else $error("granted write not on the port");

    // port goes back to read-idle
    idle_reads: assert property (@(posedge clk) disable iff (reset)
        !write_gnt |=> sram_wen)
        else $error("sram_wen low without a write grant");

    // no request, so the port stays idle and keeps its address
    no_req_no_access: assert property (@(posedge clk) disable iff (reset)
        !fetch_req && !write_req |=> sram_wen && $stable(sram_a))
        else $error("port changed without a request");

    finish_holds: assert property (@(posedge clk) disable iff (reset)
        finish |=> finish)
        else $error("finish fell without a reset");

endmodule

// arbiter connections as seen from the top level
bind huffman_top huffman_asserts i_huffman_asserts (
    .clk       (clk),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_gnt (fetch_gnt),
    .fetch_addr(fetch_addr),
    .write_req (write_req),
    .write_gnt (write_gnt),
    .write_addr(write_addr),
    .sram_a    (sram_a),
    .sram_wen  (sram_wen),
    .finish    (finish)
);

`default_nettype wire

//--- tests/huffman_tb.sv
`timescale 1ns/1ps
`default_nettype none

module huffman_tb;

    localparam int SYMBOL_COUNT = 100;
    localparam int INPUT_BASE   = 0;
    localparam int RESULT_BASE  = 128;
    localparam int MEM_WORDS    = 1 << huffman_pkg::ADDR_W;
    localparam int NUM_TESTS    = 8;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = NUM_TESTS * 200 + NUM_TESTS * RESET_CYCLES;

    // counts of symbols 1 to 6
    localparam int ROW_COUNTS [NUM_TESTS][6] = '{
        '{20, 5, 30, 10, 15, 1},
        '{10, 10, 10, 10, 10, 10},
        '{7, 25, 3, 25, 12, 0},
        '{0, 0, 40, 0, 2, 0},
        '{0, 30, 0, 0, 0, 50},
        '{100, 0, 0, 0, 0, 0},
        '{1, 2, 3, 4, 5, 6},
        '{9, 4, 9, 4, 9, 4}
    };

    // symbols in rank order, rank 0 first
    localparam int ROW_RANK [NUM_TESTS][6] = '{
        '{3, 1, 5, 4, 2, 6},
        '{1, 2, 3, 4, 5, 6},
        '{2, 4, 5, 1, 3, 6},
        '{3, 5, 1, 2, 4, 6},
        '{6, 2, 1, 3, 4, 5},
        '{1, 2, 3, 4, 5, 6},
        '{6, 5, 4, 3, 2, 1},
        '{1, 3, 5, 2, 4, 6}
    };

    logic                           clk;
    logic                           reset;
    logic [huffman_pkg::ADDR_W-1:0] sram_a;
    logic [huffman_pkg::DATA_W-1:0] sram_d;
    logic                           sram_wen;
    logic [huffman_pkg::DATA_W-1:0] sram_q = '0;
    logic                           finish;

    logic [huffman_pkg::DATA_W-1:0] mem   [MEM_WORDS];
    logic [huffman_pkg::DATA_W-1:0] image [MEM_WORDS];
    int                             errors = 0;
    int                             monitor_errors = 0;
    int                             failed_tests = 0;
    int                             cycles = 0;
    int                             writes_seen = 0;
    logic                           finish_q = 1'b0;

    huffman_top #(
        .SYMBOL_COUNT(SYMBOL_COUNT),
        .INPUT_BASE  (INPUT_BASE),
        .RESULT_BASE (RESULT_BASE)
    ) i_huffman_top (
        .clk     (clk),
        .reset   (reset),
        .sram_q  (sram_q),
        .sram_a  (sram_a),
        .sram_d  (sram_d),
        .sram_wen(sram_wen),
        .finish  (finish)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // sram with registered read, loads its image while reset is held
    always @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a] = image[a];
            end
        end
        sram_q <= #1 mem[sram_a];
        if (!sram_wen) begin
            mem[sram_a] = sram_d;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // port writes and finish, sampled mid cycle
    always @(negedge clk) begin
        finish_q <= finish;
        if (reset) begin
            writes_seen <= 0;
        end else begin
            if (!sram_wen) begin
                writes_seen <= writes_seen + 1;
                if (int'(sram_a) < RESULT_BASE ||
                    int'(sram_a) >= RESULT_BASE + huffman_pkg::NUM_RESULTS) begin
                    $display("write to address 0x%0h outside the result area", sram_a);
                    monitor_errors <= monitor_errors + 1;
                end
            end
            if (finish && writes_seen < huffman_pkg::NUM_RESULTS) begin
                $display("finish is high after only %0d result writes", writes_seen);
                monitor_errors <= monitor_errors + 1;
            end
            if (finish_q && !finish) begin
                $display("finish fell without a reset");
                monitor_errors <= monitor_errors + 1;
            end
        end
    end

    task automatic check_value(input string name, input int got, input int expected);
        if (got !== expected) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    function automatic int code_for_rank(input int r);
        if (r == 5) begin
            return 'h1f;
        end
        return ((1 << r) - 1) << 1;
    endfunction

    function automatic int mask_for_rank(input int r);
        if (r == 5) begin
            return 'h1f;
        end
        return (1 << (r + 1)) - 1;
    endfunction

    // higher count first, lower symbol wins a tie
    task automatic compute_ranks(input int t, output int order [6]);
        bit used [6];
        int best;
        for (int r = 0; r < 6; r++) begin
            best = -1;
            for (int s = 0; s < 6; s++) begin
                if (!used[s] && (best < 0 || ROW_COUNTS[t][s] > ROW_COUNTS[t][best])) begin
                    best = s;
                end
            end
            used[best] = 1'b1;
            order[r]   = best + 1;
        end
    endtask

    task automatic fill_input(input int t);
        logic [huffman_pkg::DATA_W-1:0] bytes [SYMBOL_COUNT];
        logic [huffman_pkg::DATA_W-1:0] tmp;
        int                             n;
        int                             j;
        n = 0;
        for (int s = 0; s < 6; s++) begin
            for (int k = 0; k < ROW_COUNTS[t][s]; k++) begin
                bytes[n] = 8'(s + 1);
                n++;
            end
        end
        // padding is never a symbol
        while (n < SYMBOL_COUNT) begin
            bytes[n] = ($urandom % 2 == 0) ? 8'h00 : 8'h07;
            n++;
        end
        for (int i = SYMBOL_COUNT - 1; i > 0; i--) begin
            j        = int'($urandom % 32'(i + 1));
            tmp      = bytes[i];
            bytes[i] = bytes[j];
            bytes[j] = tmp;
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            image[a] = 8'(a ^ (a >> 8)) ^ 8'h5a;
        end
        for (int i = 0; i < SYMBOL_COUNT; i++) begin
            image[INPUT_BASE + i] = bytes[i];
        end
    endtask

    task automatic run_test(input int t);
        int order [6];
        int rank_of [6];
        int errors_before;
        errors_before = errors + monitor_errors;
        fill_input(t);
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        check_value("sram_wen", int'(sram_wen), 1);
        check_value("finish", int'(finish), 0);
        #1 reset = 1'b0;
        compute_ranks(t, order);
        for (int r = 0; r < 6; r++) begin
            check_value($sformatf("rank[%0d]", r), order[r], ROW_RANK[t][r]);
            rank_of[order[r] - 1] = r;
        end
        do begin
            @(posedge clk);
            #1;
        end while (!finish);
        for (int s = 0; s < 6; s++) begin
            check_value($sformatf("count[%0d]", s + 1),
                        int'(mem[RESULT_BASE + huffman_pkg::COUNT_OFS + s]), ROW_COUNTS[t][s]);
            check_value($sformatf("code[%0d]", s + 1),
                        int'(mem[RESULT_BASE + huffman_pkg::CODE_OFS + s]),
                        code_for_rank(rank_of[s]));
            check_value($sformatf("mask[%0d]", s + 1),
                        int'(mem[RESULT_BASE + huffman_pkg::MASK_OFS + s]),
                        mask_for_rank(rank_of[s]));
        end
        // finish has to hold until the next reset
        repeat (4) @(posedge clk);
        if (errors + monitor_errors == errors_before) begin
            $display("test %0d: pass", t);
        end else begin
            $display("test %0d: fail", t);
            failed_tests++;
        end
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(32'h7d84));
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests,
                 errors + monitor_errors);
        if (errors + monitor_errors == 0 && failed_tests == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/huffman_pkg.sv
rtl/sram_port_arbiter.sv
rtl/symbol_fetch.sv
rtl/rank_sorter.sv
rtl/code_builder.sv
rtl/result_writer.sv
rtl/huffman_top.sv
tests/huffman_asserts.sv
tests/huffman_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module huffman_tb -o huffman_sim; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/huffman_sim 2>&1)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
